// ==== rmii_receive_pkg.sv ====
/*
  Shared types and constants of the RMII receive port
  Symbol and byte types, CRC-32 constants, frame limits,
  buffer sizing and output credit sizing
*/
package rmii_receive_pkg;

    //////////////////////////////
    // Types
    //////////////////////////////

    typedef logic [1:0]  dibit_t;
    typedef logic [7:0]  byte_t;
    typedef logic [31:0] crc_t;

    //////////////////////////////
    // Frame format
    //////////////////////////////

    localparam byte_t PREAMBLE_BYTE = 8'h55;
    localparam byte_t SFD_BYTE      = 8'hD5;

    // Reflected CRC-32 as used by the Ethernet FCS
    localparam crc_t CRC_POLY    = 32'hEDB88320;
    localparam crc_t CRC_INIT    = 32'hFFFFFFFF;
    localparam crc_t FCS_RESIDUE = 32'hDEBB20E3;

    localparam int FCS_BYTES = 4;

    // Bytes after the delimiter, FCS included
    localparam int MIN_FRAME_BYTES = 64;

    //////////////////////////////
    // Frame store
    //////////////////////////////

    localparam int BUFFER_BYTES = 2048;

    typedef logic [$clog2(BUFFER_BYTES)-1:0] buffer_addr_t;

    // Credits held by the receiver after reset
    localparam int CREDIT_COUNT = 4;

    typedef logic [2:0] credit_t;

endpackage

// ==== rmii_byte_packager.sv ====
/*
  RMII byte packager
  Collects receive dibits into bytes, least significant first,
  and reports the end of each frame with its error status
*/
`timescale 1ns/1ps

module rmii_byte_packager
    import rmii_receive_pkg::*;
(
    input  logic    clock,
    input  logic    reset,
    input  dibit_t  rmii_receive_data,
    input  logic    rmii_receive_data_enable,
    input  logic    rmii_receive_data_error,

    output byte_t   byte_data,
    output logic    byte_valid,
    output logic    frame_end,
    output logic    frame_error
);

logic           enable_previous;
logic           frame_start;
logic   [1:0]   dibit_count;
logic   [1:0]   dibit_index;
logic           error_seen;

assign frame_start = rmii_receive_data_enable && !enable_previous;

// Byte alignment restarts with every frame
assign dibit_index = frame_start ? 2'd0 : dibit_count;

always_ff @(posedge clock) begin
    if (reset) begin
        enable_previous <= 1'b0;
        dibit_count     <= 2'd0;
        error_seen      <= 1'b0;
        byte_valid      <= 1'b0;
        frame_end       <= 1'b0;
    end else begin
        enable_previous <= rmii_receive_data_enable;
        byte_valid      <= rmii_receive_data_enable && (dibit_index == 2'd3);
        frame_end       <= enable_previous && !rmii_receive_data_enable;
        if (rmii_receive_data_enable) begin
            dibit_count <= dibit_index + 2'd1;
            // Sticky for the whole frame
            error_seen  <= (error_seen && !frame_start) || rmii_receive_data_error;
        end
    end
end

// New dibits enter at the top, so the first one ends in bits 1:0
always_ff @(posedge clock) begin
    if (rmii_receive_data_enable) begin
        byte_data <= {rmii_receive_data, byte_data[7:2]};
    end
    frame_error <= error_seen;
end

endmodule

// ==== ethernet_frame_checker.sv ====
/*
  Ethernet frame checker
  Finds preamble and delimiter, forwards the frame body,
  checks CRC-32 and length and gives one verdict per frame
*/
`timescale 1ns/1ps

module ethernet_frame_checker
    import rmii_receive_pkg::*;
(
    input  logic    clock,
    input  logic    reset,
    input  byte_t   byte_data,
    input  logic    byte_valid,
    input  logic    frame_end,
    input  logic    frame_error,

    output byte_t   body_data,
    output logic    body_valid,
    output logic    frame_good,
    output logic    frame_bad
);

typedef enum logic [1:0] {
    STATE_HUNT,
    STATE_BODY,
    STATE_SKIP
} checker_state_t;

checker_state_t state;
logic           preamble_seen;
crc_t           crc;
logic   [6:0]   body_length;
logic           crc_match;
logic           length_ok;
logic           verdict_good;

// One byte of the reflected CRC-32, low bit first
function automatic crc_t crc_update(input crc_t crc_in, input byte_t data);
    crc_t value;
    value = crc_in ^ {24'd0, data};
    for (int bit_index = 0; bit_index < 8; bit_index++) begin
        if (value[0]) begin
            value = (value >> 1) ^ CRC_POLY;
        end else begin
            value = value >> 1;
        end
    end
    return value;
endfunction

assign crc_match    = (crc == FCS_RESIDUE);
assign length_ok    = (body_length >= 7'(MIN_FRAME_BYTES));
assign verdict_good = crc_match && length_ok && !frame_error;

//////////////////////////////
// Frame FSM
//////////////////////////////

always_ff @(posedge clock) begin
    if (reset) begin
        state         <= STATE_HUNT;
        preamble_seen <= 1'b0;
        body_valid    <= 1'b0;
        frame_good    <= 1'b0;
        frame_bad     <= 1'b0;
    end else begin
        body_valid <= 1'b0;
        frame_good <= 1'b0;
        frame_bad  <= 1'b0;
        case (state)
            STATE_HUNT: begin
                if (frame_end) begin
                    preamble_seen <= 1'b0;
                end else if (byte_valid) begin
                    if (byte_data == PREAMBLE_BYTE) begin
                        preamble_seen <= 1'b1;
                    end else if (byte_data == SFD_BYTE && preamble_seen) begin
                        preamble_seen <= 1'b0;
                        state         <= STATE_BODY;
                    end else begin
                        // Not a frame start, ignore the rest of it
                        preamble_seen <= 1'b0;
                        state         <= STATE_SKIP;
                    end
                end
            end
            STATE_BODY: begin
                body_valid <= byte_valid;
                if (frame_end) begin
                    frame_good <= verdict_good;
                    frame_bad  <= !verdict_good;
                    state      <= STATE_HUNT;
                end
            end
            STATE_SKIP: begin
                if (frame_end) begin
                    state <= STATE_HUNT;
                end
            end
            default: begin
                state <= STATE_HUNT;
            end
        endcase
    end
end

// CRC and length, seeded while hunting
always_ff @(posedge clock) begin
    body_data <= byte_data;
    if (state == STATE_HUNT) begin
        crc         <= CRC_INIT;
        body_length <= 7'd0;
    end else if (state == STATE_BODY && byte_valid) begin
        crc <= crc_update(crc, byte_data);
        if (!length_ok) begin
            body_length <= body_length + 7'd1;
        end
    end
end

endmodule

// ==== frame_store.sv ====
/*
  Store and forward frame buffer
  Circular byte buffer with commit and rewind of whole frames,
  FCS removal and credit controlled byte output
*/
`timescale 1ns/1ps

module frame_store
    import rmii_receive_pkg::*;
(
    input  logic    clock,
    input  logic    reset,
    input  byte_t   body_data,
    input  logic    body_valid,
    input  logic    frame_good,
    input  logic    frame_bad,
    input  logic    receive_credit,

    output byte_t   receive_data,
    output logic    receive_data_last,
    output logic    receive_data_valid
);

// Each entry holds a byte and its last flag in bit 8
logic   [8:0]   buffer_memory [BUFFER_BYTES];

buffer_addr_t   write_pointer;
buffer_addr_t   commit_pointer;
buffer_addr_t   read_pointer;
buffer_addr_t   rewind_pointer;
buffer_addr_t   last_pointer;

// Most recent body bytes, newest at index 0
byte_t          tail_bytes [FCS_BYTES+1];

logic           overflow;
logic           buffer_full;
logic           write_enable;
logic           commit;
logic           data_ready;
logic           read_issue;
credit_t        credits;

// One entry stays free so full and empty differ
assign buffer_full    = (write_pointer + buffer_addr_t'(1)) == read_pointer;
assign write_enable   = body_valid && !buffer_full && !overflow;

assign rewind_pointer = write_pointer - buffer_addr_t'(FCS_BYTES);
assign last_pointer   = rewind_pointer - buffer_addr_t'(1);
assign commit         = frame_good && !overflow;

assign data_ready     = (read_pointer != commit_pointer);
assign read_issue     = data_ready && (credits != credit_t'(0));

//////////////////////////////
// Write side
//////////////////////////////

always_ff @(posedge clock) begin
    if (reset) begin
        write_pointer  <= '0;
        commit_pointer <= '0;
        overflow       <= 1'b0;
    end else begin
        if (commit) begin
            // Drop the FCS and release the frame
            write_pointer  <= rewind_pointer;
            commit_pointer <= rewind_pointer;
            overflow       <= 1'b0;
        end else if (frame_good || frame_bad) begin
            write_pointer <= commit_pointer;
            overflow      <= 1'b0;
        end else if (body_valid) begin
            if (write_enable) begin
                write_pointer <= write_pointer + buffer_addr_t'(1);
            end else begin
                overflow <= 1'b1;
            end
        end
    end
end

// Single write port, verdict and body bytes never coincide
always_ff @(posedge clock) begin
    if (commit) begin
        buffer_memory[last_pointer] <= {1'b1, tail_bytes[FCS_BYTES]};
    end else if (write_enable) begin
        buffer_memory[write_pointer] <= {1'b0, body_data};
    end
    if (body_valid) begin
        tail_bytes[0] <= body_data;
        for (int i = FCS_BYTES; i > 0; i--) begin
            tail_bytes[i] <= tail_bytes[i-1];
        end
    end
end

//////////////////////////////
// Read side
//////////////////////////////

always_ff @(posedge clock) begin
    if (reset) begin
        read_pointer       <= '0;
        credits            <= credit_t'(CREDIT_COUNT);
        receive_data_valid <= 1'b0;
    end else begin
        if (read_issue) begin
            read_pointer <= read_pointer + buffer_addr_t'(1);
        end
        credits            <= credits - credit_t'(read_issue) + credit_t'(receive_credit);
        receive_data_valid <= read_issue;
    end
end

always_ff @(posedge clock) begin
    if (read_issue) begin
        {receive_data_last, receive_data} <= buffer_memory[read_pointer];
    end
end

endmodule

// ==== rmii_receive_port.sv ====
/*
  RMII receive port top level
  Byte packager, frame checker and frame store in one clock domain
*/
`timescale 1ns/1ps

module rmii_receive_port
    import rmii_receive_pkg::*;
(
    input  logic    clock,
    input  logic    reset,
    input  dibit_t  rmii_receive_data,
    input  logic    rmii_receive_data_enable,
    input  logic    rmii_receive_data_error,
    input  logic    receive_credit,

    output byte_t   receive_data,
    output logic    receive_data_last,
    output logic    receive_data_valid
);

byte_t  byte_data;
logic   byte_valid;
logic   frame_end;
logic   frame_error;

byte_t  body_data;
logic   body_valid;
logic   frame_good;
logic   frame_bad;

// Decode
rmii_byte_packager rmii_byte_packager (
    .clock                      (clock),
    .reset                      (reset),
    .rmii_receive_data          (rmii_receive_data),
    .rmii_receive_data_enable   (rmii_receive_data_enable),
    .rmii_receive_data_error    (rmii_receive_data_error),
    .byte_data                  (byte_data),
    .byte_valid                 (byte_valid),
    .frame_end                  (frame_end),
    .frame_error                (frame_error)
);

// Execute
ethernet_frame_checker ethernet_frame_checker (
    .clock          (clock),
    .reset          (reset),
    .byte_data      (byte_data),
    .byte_valid     (byte_valid),
    .frame_end      (frame_end),
    .frame_error    (frame_error),
    .body_data      (body_data),
    .body_valid     (body_valid),
    .frame_good     (frame_good),
    .frame_bad      (frame_bad)
);

// Result
frame_store frame_store (
    .clock              (clock),
    .reset              (reset),
    .body_data          (body_data),
    .body_valid         (body_valid),
    .frame_good         (frame_good),
    .frame_bad          (frame_bad),
    .receive_credit     (receive_credit),
    .receive_data       (receive_data),
    .receive_data_last  (receive_data_last),
    .receive_data_valid (receive_data_valid)
);

endmodule

// ==== rmii_receive_port_tb.sv ====
/*
  Testbench for the RMII receive port
  Random frame generator with its own CRC-32 model,
  expected byte queue, delayed credit return and checks
*/
`timescale 1ns/1ps

module rmii_receive_port_tb
    import rmii_receive_pkg::*;
;

typedef enum int {
    FRAME_GOOD,
    FRAME_BAD_FCS,
    FRAME_RX_ERROR,
    FRAME_SHORT,
    FRAME_NO_SFD
} frame_kind_t;

localparam int DRAIN_TIMEOUT_CYCLES = 40000;

logic   clock;
logic   reset;
dibit_t rmii_receive_data;
logic   rmii_receive_data_enable;
logic   rmii_receive_data_error;
logic   receive_credit = 1'b0;
byte_t  receive_data;
logic   receive_data_last;
logic   receive_data_valid;

// Expected output bytes with the last flag in bit 8
logic   [8:0]   expected_bytes [$];
// Cycle at which each pending credit goes back
int             credit_due [$];
int             cycle_count = 0;
int             hold_until = 0;
int             outstanding = 0;
string          test_name = "reset";

rmii_receive_port dut0 (
    .clock                    (clock),
    .reset                    (reset),
    .rmii_receive_data        (rmii_receive_data),
    .rmii_receive_data_enable (rmii_receive_data_enable),
    .rmii_receive_data_error  (rmii_receive_data_error),
    .receive_credit           (receive_credit),
    .receive_data             (receive_data),
    .receive_data_last        (receive_data_last),
    .receive_data_valid       (receive_data_valid)
);

always #20 clock = ~clock;

//////////////////////////////
// Checks
//////////////////////////////

task automatic abort_run(input string message);
    $display("%s", message);
    $display("Test failures found");
    $fatal(1);
endtask

task automatic check_value(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
    if (expected !== actual) begin
        abort_run($sformatf("ERROR %s: expected %0h, actual %0h", name, expected, actual));
    end
endtask

// Bit serial CRC-32 with feedback from register low bit and data bit
function automatic crc_t crc_step(input crc_t value, input byte_t data);
    crc_t   next;
    logic   feedback;
    next = value;
    for (int b = 0; b < 8; b++) begin
        feedback = next[0] ^ data[b];
        next = next >> 1;
        if (feedback) begin
            next = next ^ CRC_POLY;
        end
    end
    return next;
endfunction

//////////////////////////////
// Frame generator
//////////////////////////////

task automatic send_frame(input frame_kind_t kind);
    byte_t  body [$];
    byte_t  frame [$];
    crc_t   crc;
    int     body_length;
    int     error_dibit;
    int     flip_bit;
    error_dibit = -1;
    if (kind == FRAME_SHORT) begin
        body_length = int'($urandom_range(MIN_FRAME_BYTES - FCS_BYTES - 1, 1));
    end else begin
        body_length = int'($urandom_range(200, 60));
    end
    for (int i = 0; i < body_length; i++) begin
        body.push_back(byte_t'($urandom));
    end
    // A leading 0x55 could pair with a random 0xD5
    if (kind == FRAME_NO_SFD && body[0] == PREAMBLE_BYTE) begin
        body[0] = 8'hAA;
    end
    crc = CRC_INIT;
    foreach (body[i]) begin
        crc = crc_step(crc, body[i]);
    end
    crc = ~crc;
    if (kind == FRAME_BAD_FCS) begin
        flip_bit = int'($urandom_range(31, 0));
        crc[flip_bit] = ~crc[flip_bit];
    end
    // A burst without delimiter still carries a valid FCS
    if (kind != FRAME_NO_SFD) begin
        for (int i = 0; i < 7; i++) begin
            frame.push_back(PREAMBLE_BYTE);
        end
        frame.push_back(SFD_BYTE);
    end
    foreach (body[i]) begin
        frame.push_back(body[i]);
    end
    for (int k = 0; k < FCS_BYTES; k++) begin
        frame.push_back(crc[8*k +: 8]);
    end
    if (kind == FRAME_RX_ERROR) begin
        error_dibit = (8 + int'($urandom_range(body_length - 1, 0))) * 4
                    + int'($urandom_range(3, 0));
    end
    if (kind == FRAME_GOOD) begin
        foreach (body[i]) begin
            expected_bytes.push_back({i == body_length - 1, body[i]});
        end
    end
    // Least significant dibit first
    for (int i = 0; i < frame.size(); i++) begin
        for (int d = 0; d < 4; d++) begin
            @(negedge clock);
            rmii_receive_data_enable = 1'b1;
            rmii_receive_data        = frame[i][2*d +: 2];
            rmii_receive_data_error  = (i * 4 + d == error_dibit);
        end
    end
    @(negedge clock);
    rmii_receive_data_enable = 1'b0;
    rmii_receive_data_error  = 1'b0;
    rmii_receive_data        = 2'd0;
    repeat ($urandom_range(40, 12)) @(negedge clock);
endtask

task automatic wait_for_drain();
    int waited;
    waited = 0;
    while (expected_bytes.size() != 0 || credit_due.size() != 0) begin
        if (waited == DRAIN_TIMEOUT_CYCLES) begin
            abort_run("Timed out waiting for expected bytes and credit returns");
        end else begin
            @(negedge clock);
            waited++;
        end
    end
endtask

//////////////////////////////
// Output monitor and credits
//////////////////////////////

always @(negedge clock) begin : output_monitor
    logic [8:0] expected;
    cycle_count++;
    receive_credit = 1'b0;
    if (!reset && receive_data_valid) begin
        if (expected_bytes.size() == 0) begin
            abort_run($sformatf("Output byte %0h appeared with no good frame pending",
                                receive_data));
        end else begin
            expected = expected_bytes.pop_front();
            check_value({test_name, " data"}, 32'(expected[7:0]), 32'(receive_data));
            check_value({test_name, " last"}, 32'(expected[8]), 32'(receive_data_last));
            credit_due.push_back(cycle_count + int'($urandom_range(20, 0)));
            outstanding++;
            check_value({test_name, " credit limit"}, 32'd1,
                        32'(outstanding <= CREDIT_COUNT));
        end
    end
    // Credits withheld until hold_until
    if (cycle_count >= hold_until && credit_due.size() != 0) begin
        if (credit_due[0] <= cycle_count) begin
            void'(credit_due.pop_front());
            receive_credit = 1'b1;
            outstanding--;
        end
    end
end

//////////////////////////////
// Test sequence
//////////////////////////////

initial begin
    clock                    = 1'b0;
    reset                    = 1'b1;
    rmii_receive_data        = 2'd0;
    rmii_receive_data_enable = 1'b0;
    rmii_receive_data_error  = 1'b0;
    void'($urandom(81));
    repeat (16) @(negedge clock);
    reset = 1'b0;

    test_name = "good frames";
    repeat (6) send_frame(FRAME_GOOD);
    wait_for_drain();

    test_name = "bad fcs";
    send_frame(FRAME_BAD_FCS);
    send_frame(FRAME_GOOD);
    wait_for_drain();

    test_name = "receive error";
    send_frame(FRAME_RX_ERROR);
    send_frame(FRAME_GOOD);
    wait_for_drain();

    test_name = "short frame";
    send_frame(FRAME_SHORT);
    send_frame(FRAME_GOOD);
    wait_for_drain();

    test_name = "no delimiter";
    send_frame(FRAME_NO_SFD);
    send_frame(FRAME_GOOD);
    wait_for_drain();

    // Output of earlier frames stalls while credits are held
    test_name = "credit hold";
    send_frame(FRAME_GOOD);
    send_frame(FRAME_GOOD);
    @(posedge clock);
    hold_until = cycle_count + 200;
    send_frame(FRAME_GOOD);
    wait_for_drain();

    test_name = "random mix";
    repeat (20) send_frame(frame_kind_t'($urandom_range(4, 0)));
    wait_for_drain();

    $display("All tests passed!");
    $finish;
end

endmodule

// ==== rmii_receive_port.f ====
rmii_receive_pkg.sv
rmii_byte_packager.sv
ethernet_frame_checker.sv
frame_store.sv
rmii_receive_port.sv
rmii_receive_port_tb.sv

// ==== Makefile ====
# Verilator build and run of the RMII receive port testbench

SIM       = verilator
SIM_FLAGS = --binary --timing -j 0
TOP       = rmii_receive_port_tb
FILELIST  = rmii_receive_port.f
BUILD_DIR = obj_dir

SOURCES := $(shell grep -v '^+' $(FILELIST))
BINARY  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BINARY): $(SOURCES) $(FILELIST)
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BINARY)
	./$(BINARY)

clean:
	rm -rf $(BUILD_DIR)
